//--- sim/chain_trace.txt
# op dest data expected_err expected_data
# dest and expected_err are decimal, data and expected_data are hex
test reset_reads
read 0 00000000 0 00000000
read 1 00000000 0 00000000
read 2 00000000 0 00000000
read 3 00000000 0 00000000
test write_read
write 1 deadbeef 0 00000000
read 1 00000000 0 deadbeef
read 0 00000000 0 00000000
write 1 12345678 0 deadbeef
test add_wrap
write 2 fffffff0 0 00000000
add 2 00000008 0 fffffff8
add 2 00000010 0 00000008
test unclaimed
write 4 00000055 1 00000000
read 5 00000000 1 00000000
add 7 00000001 1 00000000
read 1 00000000 0 12345678
test back_to_back
write 0 a5a5a5a5 0 00000000
add 3 00000001 0 00000001
read 0 00000000 0 a5a5a5a5
read 6 00000000 1 00000000
add 2 00000002 0 0000000a
read 1 00000000 0 12345678
write 3 00000077 0 00000001
read 3 00000000 0 00000077
read 2 00000000 0 0000000a

//--- chain_top.f
hw/chain_pkg.sv
hw/chain_injector.sv
hw/chain_tile.sv
hw/chain_collector.sv
hw/chain_top.sv
sim/chain_sva.sv
sim/chain_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= chain_tb
LINT_TOP  ?= chain_top
FILELIST  ?= chain_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only --timing -Wall --timescale 1ns/1ps

SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Errors found" $(LOG); then echo "FAILED, see $(LOG)"; exit 1; fi
	@grep -q "No errors" $(LOG) || { echo "FAILED, run ended early, see $(LOG)"; exit 1; }
	@echo "PASSED"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/chain_tb.sv
`timescale 1ns/1ps
`default_nettype none

module chain_tb;

   import chain_pkg::*;

   localparam int unsigned num_tiles_lp = 4;

   logic        clk;
   logic        rst;
   logic        cmd_v;
   chain_cmd_t  cmd;
   logic        resp_v;
   chain_resp_t resp;

   chain_cmd_t  cmd_a[$];        // trace commands in file order
   chain_resp_t exp_a[$];        // their expected responses, the tag is filled in when sent
   int          grp_a[$];
   string       grp_name[$];
   chain_resp_t exp_q[$];        // responses the DUT still owes
   chain_resp_t exp_resp;
   logic [31:0] rnd_state = 32'd47;
   logic [chain_tag_width_c-1:0] tag_cnt = '0;
   int          errors = 0;
   int          checks = 0;
   int          grp_err_base = 0;
   bit          trace_done = 1'b0;

   chain_top
    #(.num_tiles_p(num_tiles_lp)
      )
    u_chain_top
     (.clk_i(clk)
      ,.rst_i(rst)
      ,.cmd_v_i(cmd_v)
      ,.cmd_i(cmd)
      ,.resp_v_o(resp_v)
      ,.resp_o(resp)
      );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_field(input string name, input logic [31:0] got,
                              input logic [31:0] exp_v);
      checks++;
      if (got !== exp_v)
      begin
         $display("[FAIL] %0t: %s is %h, expected %h", $time, name, got, exp_v);
         errors++;
      end
   endtask

   task automatic read_trace();
      int          fd;
      int          n;
      int          dest;
      int          err;
      logic [31:0] data;
      logic [31:0] exp_data;
      string       tok;
      string       rest;
      chain_cmd_t  c;
      chain_resp_t r;
      fd = $fopen("sim/chain_trace.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open sim/chain_trace.txt, so no command was run");
         errors++;
      end
      else
      begin
         while ($fscanf(fd, "%s", tok) == 1)
         begin
            if (tok == "#")
               n = $fgets(rest, fd);            // column legend
            else if (tok == "test")
            begin
               n = $fscanf(fd, "%s", tok);
               grp_name.push_back(tok);
            end
            else
            begin
               n = $fscanf(fd, "%d %h %d %h", dest, data, err, exp_data);
               if (n != 4 || (tok != "read" && tok != "write" && tok != "add"))
               begin
                  $display("trace line starting with '%s' cannot be parsed", tok);
                  errors++;
               end
               c.op   = (tok == "write") ? op_write : ((tok == "add") ? op_add : op_read);
               c.dest = chain_x_width_c'(dest);
               c.data = data;
               r.tag  = '0;
               r.src  = chain_x_width_c'(dest);   // source of a response is always its target
               r.err  = err[0];
               r.data = exp_data;
               cmd_a.push_back(c);
               exp_a.push_back(r);
               grp_a.push_back(grp_name.size());
            end
         end
         $fclose(fd);
      end
      trace_done = 1'b1;
   endtask

   // a group is over once every response it asked for has come back
   task automatic finish_group(input int g);
      while (exp_q.size() != 0)
         @(negedge clk);
      $display("test %0d %s finished with %0d errors", g,
               (g > 0) ? grp_name[g-1] : "unnamed", errors - grp_err_base);
      grp_err_base = errors;
   endtask

   always @(negedge clk)
   begin
      if (resp_v)
      begin
         if (exp_q.size() == 0)
         begin
            $display("a response with tag %0d came at %0t with no command waiting for it",
                     resp.tag, $time);
            errors++;
         end
         else
         begin
            exp_resp = exp_q.pop_front();
            check_field("tag", 32'(resp.tag), 32'(exp_resp.tag));
            check_field("src", 32'(resp.src), 32'(exp_resp.src));
            check_field("err", 32'(resp.err), 32'(exp_resp.err));
            check_field("data", resp.data, exp_resp.data);
         end
      end
   end

   initial
   begin
      int unsigned limit;
      wait (trace_done);
      limit = cmd_a.size() * 4 + num_tiles_lp + 2 + 50;
      #(limit * 10);
      $display("timeout after %0d cycles with %0d responses still missing", limit, exp_q.size());
      $display("Errors found");
      $finish;
   end

   initial
   begin
      chain_resp_t r;
      int          gap;
      rst   = 1'b1;
      cmd_v = 1'b0;
      cmd   = '0;
      read_trace();
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      for (int i = 0; i < cmd_a.size(); i++)
      begin
         if (i > 0 && grp_a[i] != grp_a[i-1])
            finish_group(grp_a[i-1]);
         r     = exp_a[i];
         r.tag = tag_cnt;
         exp_q.push_back(r);
         cmd   = cmd_a[i];
         cmd_v = 1'b1;
         tag_cnt++;
         @(negedge clk);
         cmd_v     = 1'b0;
         rnd_state = xorshift32(rnd_state);
         gap       = (grp_a[i] == 5) ? 0 : int'(rnd_state % 4);   // group 5 runs back to back
         repeat (gap) @(negedge clk);
      end
      if (cmd_a.size() > 0)
         finish_group(grp_a[cmd_a.size()-1]);
      else
      begin
         $display("the trace held no commands");
         errors++;
      end
      $display("summary: %0d commands, %0d field checks, %0d errors", cmd_a.size(), checks,
               errors);
      if (errors == 0)
         $display("No errors");
      else
         $display("Errors found");
      $finish;
   end

endmodule : chain_tb

`default_nettype wire

//--- sim/chain_sva.sv
`timescale 1ns/1ps
`default_nettype none

module chain_sva
 #(parameter int unsigned num_tiles_p = 4
   )
  (input  logic                   clk_i
   , input  logic                 rst_i
   , input  logic                 cmd_v_i
   , input  logic                 resp_v_i
   , input  chain_pkg::chain_resp_t resp_i
   );

   import chain_pkg::*;

   localparam int unsigned lat_lp = num_tiles_p + 2;

   int unsigned run_cnt_r;   // edges since reset went low, saturates at lat_lp + 1

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         run_cnt_r <= 0;
      end
      else if (run_cnt_r <= lat_lp)
      begin
         run_cnt_r <= run_cnt_r + 1;
      end
   end

   a_quiet_reset: assert property (@(posedge clk_i) rst_i |=> !resp_v_i)
      else $error("resp_v_o high during reset or on the cycle after it");

   // injector, every tile and the collector each add one stage
   a_latency: assert property (@(posedge clk_i)
      (run_cnt_r > lat_lp) |-> (resp_v_i == $past(cmd_v_i, lat_lp)))
      else $error("resp_v_o does not follow cmd_v_i after %0d cycles", lat_lp);

   a_err_no_data: assert property (@(posedge clk_i)
      (resp_v_i && resp_i.err) |-> (resp_i.data == '0))
      else $error("error response carries nonzero data");

endmodule : chain_sva

bind chain_top chain_sva
 #(.num_tiles_p(num_tiles_p)
   )
 u_chain_sva
  (.clk_i(clk_i)
   ,.rst_i(rst_i)
   ,.cmd_v_i(cmd_v_i)
   ,.resp_v_i(resp_v_o)
   ,.resp_i(resp_o)
   );

`default_nettype wire

//--- hw/chain_top.sv
`timescale 1ns/1ps
`default_nettype none

module chain_top
 #(parameter int unsigned num_tiles_p = 4
   )
  (input  logic                  clk_i
   , input  logic                rst_i

   , input  logic                cmd_v_i
   , input  chain_pkg::chain_cmd_t cmd_i

   , output logic                resp_v_o
   , output chain_pkg::chain_resp_t resp_o
   );

   import chain_pkg::*;

   // entry i feeds tile i, the last entry feeds the collector
   chain_link_t [num_tiles_p:0] link_stitch;

   chain_injector u_injector
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.cmd_v_i(cmd_v_i)
      ,.cmd_i(cmd_i)
      ,.link_o(link_stitch[0])
      );

   for (genvar i = 0; i < num_tiles_p; i++)
   begin : g_tile
      chain_tile
       #(.tile_id_p(i)
         )
       u_tile
        (.clk_i(clk_i)
         ,.rst_i(rst_i)
         ,.link_i(link_stitch[i])
         ,.link_o(link_stitch[i+1])
         );
   end

   chain_collector
    #(.num_tiles_p(num_tiles_p)
      )
    u_collector
     (.clk_i(clk_i)
      ,.rst_i(rst_i)
      ,.link_i(link_stitch[num_tiles_p])
      ,.resp_v_o(resp_v_o)
      ,.resp_o(resp_o)
      );

endmodule : chain_top

`default_nettype wire

//--- hw/chain_collector.sv
`timescale 1ns/1ps
`default_nettype none

module chain_collector
 #(parameter int unsigned num_tiles_p = 4
   )
  (input  logic                  clk_i
   , input  logic                rst_i

   , input  chain_pkg::chain_link_t link_i

   , output logic                resp_v_o
   , output chain_pkg::chain_resp_t resp_o
   );

   import chain_pkg::*;

   // every tile index has to fit in the x field of a link
   if ((num_tiles_p < 1) || (num_tiles_p > (1 << chain_x_width_c)))
   begin : g_param_check
      $error("chain_collector: num_tiles_p must lie within 1 to 8");
   end

   chain_resp_t resp_n;
   chain_resp_t resp_r;
   logic        resp_v_r;

   always_comb
   begin
      resp_n.tag = link_i.tag;
      resp_n.src = link_i.x;          // a request that got here still carries its destination
      if (link_i.is_resp)
      begin
         resp_n.err  = 1'b0;
         resp_n.data = link_i.data;
      end
      else
      begin
         resp_n.err  = 1'b1;          // destination lies past the last tile
         resp_n.data = '0;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         resp_v_r <= 1'b0;
      end
      else
      begin
         resp_v_r <= link_i.v;
      end
   end

   // hold the last response between strobes
   always_ff @(posedge clk_i)
   begin
      if (link_i.v)
      begin
         resp_r <= resp_n;
      end
   end

   assign resp_v_o = resp_v_r;
   assign resp_o   = resp_r;

endmodule : chain_collector

`default_nettype wire

//--- hw/chain_tile.sv
`timescale 1ns/1ps
`default_nettype none

module chain_tile
 #(parameter int unsigned tile_id_p = 0
   )
  (input  logic                  clk_i
   , input  logic                rst_i

   , input  chain_pkg::chain_link_t link_i
   , output chain_pkg::chain_link_t link_o
   );

   import chain_pkg::*;

   // own index at the width of the x field
   localparam logic [chain_x_width_c-1:0] my_x_lp = chain_x_width_c'(tile_id_p);

   logic [chain_data_width_c-1:0] cfg_r;
   logic [chain_data_width_c-1:0] cfg_n;
   logic [chain_data_width_c-1:0] ret_data;
   logic                          hit;
   chain_link_t                   link_n;
   chain_link_t                   link_r;

   // responses are never looked at again, only forwarded
   assign hit = link_i.v & ~link_i.is_resp & (link_i.x == my_x_lp);

   always_comb
   begin
      cfg_n    = cfg_r;
      ret_data = cfg_r;
      case (link_i.op)
         op_write:
         begin
            cfg_n    = link_i.data;
            ret_data = cfg_r;                 // old value goes back
         end
         op_add:
         begin
            cfg_n    = cfg_r + link_i.data;   // wraps modulo 2^32
            ret_data = cfg_n;
         end
         default:
         begin
            cfg_n    = cfg_r;
            ret_data = cfg_r;
         end
      endcase
   end

   always_comb
   begin
      link_n = link_i;
      if (hit)
      begin
         // the response takes over the slot of the request
         link_n.is_resp = 1'b1;
         link_n.x       = my_x_lp;
         link_n.data    = ret_data;
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         cfg_r <= '0;
      end
      else if (hit)
      begin
         cfg_r <= cfg_n;
      end
   end

   // hop register, one cycle per tile whether claimed or not
   always_ff @(posedge clk_i)
   begin
      link_r <= link_n;
      if (rst_i)
      begin
         link_r.v <= 1'b0;
      end
   end

   assign link_o = link_r;

endmodule : chain_tile

`default_nettype wire

//--- hw/chain_injector.sv
`timescale 1ns/1ps
`default_nettype none

module chain_injector
  (input  logic                  clk_i
   , input  logic                rst_i

   , input  logic                cmd_v_i
   , input  chain_pkg::chain_cmd_t cmd_i

   , output chain_pkg::chain_link_t link_o
   );

   import chain_pkg::*;

   logic [chain_tag_width_c-1:0] tag_r;
   chain_link_t                  link_n;
   chain_link_t                  link_r;

   // one tag per accepted command, idle cycles leave it alone
   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         tag_r <= '0;
      end
      else if (cmd_v_i)
      begin
         tag_r <= tag_r + 1'b1;
      end
   end

   always_comb
   begin
      link_n.v       = cmd_v_i;
      link_n.is_resp = 1'b0;         // every packet starts out as a request
      link_n.op      = cmd_i.op;
      link_n.x       = cmd_i.dest;
      link_n.tag     = tag_r;
      link_n.data    = cmd_i.data;
   end

   // launch register in front of tile 0
   always_ff @(posedge clk_i)
   begin
      link_r <= link_n;
      if (rst_i)
      begin
         link_r.v <= 1'b0;
      end
   end

   assign link_o = link_r;

endmodule : chain_injector

`default_nettype wire

//--- hw/chain_pkg.sv
`default_nettype none

package chain_pkg;

   // register and data field width
   localparam int unsigned chain_data_width_c = 32;

   // tile index width, enough for addresses 0 to 7
   localparam int unsigned chain_x_width_c = 3;

   localparam int unsigned chain_tag_width_c = 4;   // sequence tag, wraps modulo 16

   typedef enum logic [1:0]
   {
      op_read  = 2'd0,
      op_write = 2'd1,
      op_add   = 2'd2
   } chain_op_e;

   // command as it arrives from outside the chain
   typedef struct packed
   {
      chain_op_e                     op;
      logic [chain_x_width_c-1:0]    dest;
      logic [chain_data_width_c-1:0] data;
   } chain_cmd_t;

   // one hop of the chain, a request until some tile claims it
   typedef struct packed
   {
      logic                          v;
      logic                          is_resp;
      chain_op_e                     op;
      logic [chain_x_width_c-1:0]    x;        // destination of a request, source of a response
      logic [chain_tag_width_c-1:0]  tag;
      logic [chain_data_width_c-1:0] data;
   } chain_link_t;

   typedef struct packed
   {
      logic [chain_tag_width_c-1:0]  tag;
      logic [chain_x_width_c-1:0]    src;
      logic                          err;      // no tile claimed the request
      logic [chain_data_width_c-1:0] data;
   } chain_resp_t;

endpackage : chain_pkg

`default_nettype wire
